// ==== common/fixedPointPkg.sv ====
`default_nettype none

package fixedPointPkg;

    // Signed Q12.12 position, low 4 integer bits address a map cell
    typedef logic signed [23:0] fixedT;

    localparam int fracBits = 12;   // Fraction bits in fixedT

    // Start in the middle of cell (1,13)
    localparam fixedT playerXStart = 24'sh00_1800;  // 1.5
    localparam fixedT playerYStart = 24'sh00_D800;  // 13.5

    // Walking pace per frame
    // 10 * 2^-9 which is 80 LSBs, keeps a multiple of 8 for clean steps
    localparam fixedT playerMove = 24'sd80;

endpackage

`default_nettype wire

// ==== common/videoPkg.sv ====
`default_nettype none

package videoPkg;

    typedef logic [9:0] coordT;     // Pixel coordinate, enough for 1024 positions
    typedef logic [1:0] levelT;     // 2bpp per channel, 64 colours in total

    // One pixel colour, one level per channel
    typedef struct packed {
        levelT r;
        levelT g;
        levelT b;
    } colourT;

    // Palette
    localparam colourT black        = '{r: 2'd0, g: 2'd0, b: 2'd0};
    localparam colourT darkGrey     = '{r: 2'd1, g: 2'd1, b: 2'd1};    // Ceiling
    localparam colourT lightGrey    = '{r: 2'd2, g: 2'd2, b: 2'd2};    // Floor
    localparam colourT borderPurple = '{r: 2'd1, g: 2'd0, b: 2'd1};
    localparam colourT gridBlue     = '{r: 2'd0, g: 2'd0, b: 2'd1};    // Dark blue map lines
    localparam colourT playerYellow = '{r: 2'd3, g: 2'd3, b: 2'd0};
    localparam colourT cellGreen    = '{r: 2'd0, g: 2'd1, b: 2'd0};    // Dark green

endpackage

`default_nettype wire

// ==== video/vgaTiming.sv ====
`default_nettype none

module vgaTiming #(
    parameter int hVisible = 640,
    parameter int hFront   = 16,
    parameter int hSync    = 96,
    parameter int hBack    = 48,
    parameter int vVisible = 480,
    parameter int vFront   = 10,
    parameter int vSync    = 2,
    parameter int vBack    = 33
) (
    input  logic           clk,
    input  logic           reset,
    output videoPkg::coordT h,          // Horizontal scan position
    output videoPkg::coordT v,          // Vertical scan position
    output logic           visible,
    output logic           hsync,       // Active low
    output logic           vsync,       // Active low
    output logic           frameTick,   // One cycle at the scan origin
    output logic [10:0]    frameNum
);
    import videoPkg::*;

    localparam int hTotal = hVisible + hFront + hSync + hBack;
    localparam int vTotal = vVisible + vFront + vSync + vBack;

    // Window edges as coordinates
    localparam coordT hLast      = coordT'(hTotal - 1);
    localparam coordT vLast      = coordT'(vTotal - 1);
    localparam coordT hSyncStart = coordT'(hVisible + hFront);
    localparam coordT hSyncEnd   = coordT'(hVisible + hFront + hSync);    // First cycle after pulse
    localparam coordT vSyncStart = coordT'(vVisible + vFront);
    localparam coordT vSyncEnd   = coordT'(vVisible + vFront + vSync);
    localparam coordT hVisEnd    = coordT'(hVisible);
    localparam coordT vVisEnd    = coordT'(vVisible);

    // Scan counters, v steps when h wraps
    always_ff @(posedge clk) begin
        if (reset) begin
            h        <= '0;
            v        <= '0;
            frameNum <= '0;
        end else if (h == hLast) begin
            h <= '0;
            if (v == vLast) begin
                v        <= '0;
                frameNum <= frameNum + 11'd1;   // Counts on wrap back to line 0
            end else begin
                v <= v + 10'd1;
            end
        end else begin
            h <= h + 10'd1;
        end
    end

    // Decoded straight from the counters so sync lines up with h/v
    assign hsync = !(h >= hSyncStart && h < hSyncEnd);
    assign vsync = !(v >= vSyncStart && v < vSyncEnd);

    assign visible = h < hVisEnd && v < vVisEnd;

    // Frame start, animation happens on this edge
    assign frameTick = h == '0 && v == '0;

endmodule

`default_nettype wire

// ==== video/pixelComposer.sv ====
`default_nettype none

module pixelComposer #(
    parameter int hVisible    = 640,
    parameter int vVisible    = 480,
    parameter int borderWidth = 66
) (
    input  videoPkg::coordT h,
    input  videoPkg::coordT v,
    input  logic           visible,
    input  logic           inOverlay,
    input  logic           inGridline,
    input  logic           inPlayerCell,
    input  logic           inPlayerPixel,
    input  videoPkg::levelT cellValue,     // Map value of the addressed cell
    output videoPkg::levelT red,
    output videoPkg::levelT green,
    output videoPkg::levelT blue
);
    import videoPkg::*;

    localparam coordT borderLeft  = coordT'(borderWidth);
    localparam coordT borderRight = coordT'(hVisible - borderWidth);
    localparam coordT horizon     = coordT'(vVisible / 2);

    colourT pix;        // Raw colour before blanking
    logic   inBorder;
    logic   ceiling;

    // Side bars framing the view
    assign inBorder = h < borderLeft || h >= borderRight;
    assign ceiling  = v < horizon;     // Upper half is ceiling

    // Highest priority first
    always_comb begin
        if (inPlayerPixel) begin
            pix = playerYellow;
        end else if (inPlayerCell) begin
            pix = cellGreen;
        end else if (inGridline) begin
            pix = gridBlue;
        end else if (inOverlay) begin
            pix = '{r: 2'd0, g: 2'd0, b: cellValue};   // Cell shade in blue only
        end else if (inBorder) begin
            pix = borderPurple;
        end else if (ceiling) begin
            pix = darkGrey;
        end else begin
            pix = lightGrey;    // Floor
        end
    end

    // Nothing is driven during blanking
    assign red   = visible ? pix.r : black.r;
    assign green = visible ? pix.g : black.g;
    assign blue  = visible ? pix.b : black.b;

endmodule

`default_nettype wire

// ==== player/playerState.sv ====
`default_nettype none

module playerState (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frameTick,
    input  logic                 writeNewPosition,  // Host overwrite, sampled at the tick
    input  logic                 moveL,
    input  logic                 moveR,
    input  logic                 moveF,
    input  logic                 moveB,
    input  fixedPointPkg::fixedT newPlayerX,
    input  fixedPointPkg::fixedT newPlayerY,
    output fixedPointPkg::fixedT playerX,
    output fixedPointPkg::fixedT playerY
);
    import fixedPointPkg::*;

    // Position updates once per frame only
    always_ff @(posedge clk) begin
        if (reset) begin
            playerX <= playerXStart;
            playerY <= playerYStart;
        end else if (frameTick) begin
            if (writeNewPosition) begin
                // Host position replaces motion for this frame
                playerX <= newPlayerX;
                playerY <= newPlayerY;
            end else begin
                // Left beats right
                if (moveL) begin
                    playerX <= playerX - playerMove;
                end else if (moveR) begin
                    playerX <= playerX + playerMove;
                end

                if (moveF) begin
                    playerY <= playerY - playerMove;   // Forward is up the map
                end else if (moveB) begin
                    playerY <= playerY + playerMove;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== map/mapOverlay.sv ====
`default_nettype none

module mapOverlay #(
    parameter int mapScale = 4     // Log2 of pixels per map cell
) (
    input  videoPkg::coordT      h,
    input  videoPkg::coordT      v,
    input  fixedPointPkg::fixedT playerX,
    input  fixedPointPkg::fixedT playerY,
    input  logic                 showMap,
    output logic                 inOverlay,
    output logic                 inGridline,
    output logic                 inPlayerCell,
    output logic                 inPlayerPixel,
    output videoPkg::levelT      cellValue
);
    import fixedPointPkg::*;
    import videoPkg::*;

    // 16 cells plus the closing gridline
    localparam int    overlaySizeInt = 16 * (2 ** mapScale) + 1;
    localparam coordT overlaySize    = coordT'(overlaySizeInt);

    logic [3:0]          cellCol;   // Map cell under the beam
    logic [3:0]          cellRow;
    logic [mapScale-1:0] subX;      // Pixel offset inside the cell
    logic [mapScale-1:0] subY;
    logic                onEdge;
    logic                onPost;

    assign cellCol = h[mapScale+3:mapScale];
    assign cellRow = v[mapScale+3:mapScale];
    assign subX    = h[mapScale-1:0];
    assign subY    = v[mapScale-1:0];

    // Fixed map in place of a ROM
    // Solid outer wall, with pillars on a 4-cell pitch inside
    assign onEdge = cellCol == 4'd0 || cellCol == 4'd15 || cellRow == 4'd0 || cellRow == 4'd15;
    assign onPost = cellCol[1:0] == 2'd0 && cellRow[1:0] == 2'd0;

    always_comb begin
        if (onEdge) begin
            cellValue = 2'd3;
        end else if (onPost) begin
            cellValue = 2'd1;
        end else begin
            cellValue = 2'd0;   // Open floor
        end
    end

    // Top left corner of the screen
    assign inOverlay  = showMap && h < overlaySize && v < overlaySize;
    assign inGridline = inOverlay && (subX == '0 || subY == '0);

    // Integer cell of the player vs cell on screen
    assign inPlayerCell = inOverlay
                          && playerX[fracBits+3:fracBits] == cellCol
                          && playerY[fracBits+3:fracBits] == cellRow;

    // Top fraction bits pick the pixel inside the cell
    assign inPlayerPixel = inPlayerCell
                           && playerX[fracBits-1 -: mapScale] == subX
                           && playerY[fracBits-1 -: mapScale] == subY;

endmodule

`default_nettype wire

// ==== source/raybox.sv ====
`default_nettype none

module raybox #(
    parameter int hVisible    = 640,
    parameter int hFront      = 16,
    parameter int hSync       = 96,
    parameter int hBack       = 48,
    parameter int vVisible    = 480,
    parameter int vFront      = 10,
    parameter int vSync       = 2,
    parameter int vBack       = 33,
    parameter int mapScale    = 4,     // Map overlay cell is 2^mapScale pixels
    parameter int borderWidth = 66
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 showMap,           // Map overlay on/off
    input  logic                 moveL,
    input  logic                 moveR,
    input  logic                 moveF,
    input  logic                 moveB,
    input  logic                 writeNewPosition,  // Host position load
    input  fixedPointPkg::fixedT newPlayerX,
    input  fixedPointPkg::fixedT newPlayerY,
    output videoPkg::levelT      red,
    output videoPkg::levelT      green,
    output videoPkg::levelT      blue,
    output logic                 hsync,
    output logic                 vsync,
    output videoPkg::coordT      px,                // Current pixel
    output videoPkg::coordT      py,
    output logic [10:0]          frameNum
);
    import fixedPointPkg::*;
    import videoPkg::*;

    logic  visible;
    logic  frameTick;   // Start of frame
    fixedT playerX;
    fixedT playerY;
    logic  inOverlay;
    logic  inGridline;
    logic  inPlayerCell;
    logic  inPlayerPixel;
    levelT cellValue;

    // Scan position doubles as the pixel outputs
    vgaTiming #(
        .hVisible (hVisible),
        .hFront   (hFront),
        .hSync    (hSync),
        .hBack    (hBack),
        .vVisible (vVisible),
        .vFront   (vFront),
        .vSync    (vSync),
        .vBack    (vBack)
    ) timing_i (
        .clk       (clk),
        .reset     (reset),
        .h         (px),
        .v         (py),
        .visible   (visible),
        .hsync     (hsync),
        .vsync     (vsync),
        .frameTick (frameTick),
        .frameNum  (frameNum)
    );

    playerState player_i (
        .clk              (clk),
        .reset            (reset),
        .frameTick        (frameTick),
        .writeNewPosition (writeNewPosition),
        .moveL            (moveL),
        .moveR            (moveR),
        .moveF            (moveF),
        .moveB            (moveB),
        .newPlayerX       (newPlayerX),
        .newPlayerY       (newPlayerY),
        .playerX          (playerX),
        .playerY          (playerY)
    );

    mapOverlay #(
        .mapScale (mapScale)
    ) map_i (
        .h             (px),
        .v             (py),
        .playerX       (playerX),
        .playerY       (playerY),
        .showMap       (showMap),
        .inOverlay     (inOverlay),
        .inGridline    (inGridline),
        .inPlayerCell  (inPlayerCell),
        .inPlayerPixel (inPlayerPixel),
        .cellValue     (cellValue)
    );

    // Same-cycle colour, no pipeline stage
    pixelComposer #(
        .hVisible    (hVisible),
        .vVisible    (vVisible),
        .borderWidth (borderWidth)
    ) composer_i (
        .h             (px),
        .v             (py),
        .visible       (visible),
        .inOverlay     (inOverlay),
        .inGridline    (inGridline),
        .inPlayerCell  (inPlayerCell),
        .inPlayerPixel (inPlayerPixel),
        .cellValue     (cellValue),
        .red           (red),
        .green         (green),
        .blue          (blue)
    );

endmodule

`default_nettype wire

// ==== tb/rayboxModel.svh ====
`ifndef RAYBOX_MODEL_SVH
`define RAYBOX_MODEL_SVH

// Expected palette as {r, g, b}, two bits per channel
localparam logic [5:0] colYellow = 6'b11_11_00;
localparam logic [5:0] colGreen  = 6'b00_01_00;
localparam logic [5:0] colGrid   = 6'b00_00_01;
localparam logic [5:0] colPurple = 6'b01_00_01;
localparam logic [5:0] colDark   = 6'b01_01_01;    // Ceiling
localparam logic [5:0] colLight  = 6'b10_10_10;    // Floor

// Outer wall 3, pillars every 4 cells 1, open floor 0
function automatic logic [1:0] mapValue(input int col, input int row);
    if (col == 0 || col == 15 || row == 0 || row == 15) return 2'd3;
    if (col % 4 == 0 && row % 4 == 0) return 2'd1;
    return 2'd0;
endfunction

// One frame of motion on one axis, minus button wins
function automatic logic [23:0] stepAxis(input logic [23:0] pos, input logic minus,
                                         input logic plus);
    if (minus) return pos - moveStep;
    if (plus) return pos + moveStep;
    return pos;
endfunction

// Colour at a scan position for a given map switch and player position
function automatic logic [5:0] expectedColour(input int h, input int v, input logic mapOn,
                                              input logic [23:0] posX, input logic [23:0] posY);
    int   col;
    int   row;
    int   subX;
    int   subY;
    int   fracX;
    int   fracY;
    logic overlay;
    logic playerCell;
    col        = (h >> mapScale) % 16;
    row        = (v >> mapScale) % 16;
    subX       = h % cellPixels;                        // Pixel inside the cell
    subY       = v % cellPixels;
    fracX      = int'(posX[11:0]) >> (12 - mapScale);   // Top fraction bits
    fracY      = int'(posY[11:0]) >> (12 - mapScale);
    overlay    = mapOn && h < overlaySize && v < overlaySize;
    playerCell = overlay && int'(posX[15:12]) == col && int'(posY[15:12]) == row;
    if (h >= hVisible || v >= vVisible) return 6'h00;  // Blanking
    if (playerCell && fracX == subX && fracY == subY) return colYellow;
    if (playerCell) return colGreen;
    if (overlay && (subX == 0 || subY == 0)) return colGrid;
    if (overlay) return {4'b0000, mapValue(col, row)};  // Blue shade only
    if (h < borderWidth || h >= hVisible - borderWidth) return colPurple;
    if (v < vVisible / 2) return colDark;
    return colLight;
endfunction

`endif

// ==== tb/rayboxTb.sv ====
`default_nettype none

module rayboxTb;
    timeunit 1ns;
    timeprecision 100ps;

    // Small screen of 80 x 54 cycles per frame
    localparam int hVisible    = 64;
    localparam int hFront      = 4;
    localparam int hSync       = 8;
    localparam int hBack       = 4;
    localparam int vVisible    = 48;
    localparam int vFront      = 2;
    localparam int vSync       = 2;
    localparam int vBack       = 2;
    localparam int mapScale    = 1;
    localparam int borderWidth = 6;

    localparam int hTotal      = hVisible + hFront + hSync + hBack;
    localparam int vTotal      = vVisible + vFront + vSync + vBack;
    localparam int cellPixels  = 1 << mapScale;
    localparam int overlaySize = 16 * cellPixels + 1;
    localparam int resetCycles = 16;
    localparam int runFrames   = 40;
    localparam int cycleLimit  = 45 * hTotal * vTotal + resetCycles;

    // Q12.12 start at cell (1.5, 13.5) and a step of 80 LSBs per frame
    localparam logic [23:0] startX   = 24'h00_1800;
    localparam logic [23:0] startY   = 24'h00_D800;
    localparam logic [23:0] moveStep = 24'd80;

    logic        clk = 1'b0;
    logic        reset;
    logic        showMap;
    logic        moveL;
    logic        moveR;
    logic        moveF;
    logic        moveB;
    logic        writeNewPosition;
    logic [23:0] newPlayerX;
    logic [23:0] newPlayerY;
    logic [1:0]  red;
    logic [1:0]  green;
    logic [1:0]  blue;
    logic        hsync;
    logic        vsync;
    logic [9:0]  px;
    logic [9:0]  py;
    logic [10:0] frameNum;

    logic [31:0] rngState;
    logic [23:0] modelX;        // Player position as the model sees it
    logic [23:0] modelY;
    logic [5:0]  expColour;
    logic        expHsync;      // Active low inside the sync window
    logic        expVsync;
    int          expH;
    int          expV;
    int          expFrame;
    int          errorCount = 0;
    int          checkCount = 0;
    int          yellowSeen = 0;
    int          cycleCount = 0;

    `include "rayboxModel.svh"

    raybox #(
        .hVisible (hVisible), .hFront (hFront), .hSync (hSync), .hBack (hBack),
        .vVisible (vVisible), .vFront (vFront), .vSync (vSync), .vBack (vBack),
        .mapScale (mapScale), .borderWidth (borderWidth)
    ) dut_i (
        .clk (clk), .reset (reset), .showMap (showMap),
        .moveL (moveL), .moveR (moveR), .moveF (moveF), .moveB (moveB),
        .writeNewPosition (writeNewPosition), .newPlayerX (newPlayerX),
        .newPlayerY (newPlayerY), .red (red), .green (green), .blue (blue),
        .hsync (hsync), .vsync (vsync), .px (px), .py (py), .frameNum (frameNum)
    );

    always #5 clk = ~clk;

    // xorshift32 step
    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // New frame inputs applied during vertical blanking
    task automatic randomizeInputs();
        rngState         = nextRandom(rngState);
        showMap          = rngState[1:0] != 2'b00;     // 3 of 4 frames
        writeNewPosition = rngState[4:2] == 3'b000;    // 1 of 8 frames
        {moveL, moveR, moveF, moveB} = rngState[8:5];
        rngState   = nextRandom(rngState);
        newPlayerX = {8'h00, rngState[15:0]};          // Integer part within 0..15
        newPlayerY = {8'h00, rngState[31:16]};
    endtask

    // Run limit that ends a stuck run
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the run did not reach frame %0d",
                     cycleCount, runFrames);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        reset            = 1'b1;
        showMap          = 1'b1;   // First frame shows the start position
        moveL            = 1'b0;
        moveR            = 1'b0;
        moveF            = 1'b0;
        moveB            = 1'b0;
        writeNewPosition = 1'b0;
        newPlayerX       = '0;
        newPlayerY       = '0;
        rngState         = 32'h2caf_6d3d;
        modelX           = startX;
        modelY           = startY;
        expH             = 0;
        expV             = 0;
        expFrame         = 0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (expFrame < runFrames) begin
            // Outputs are settled mid-cycle
            checkCount++;
            if (int'(px) != expH) begin
                $display("[ERROR] px = %h, expected %h", px, expH[9:0]);
                errorCount++;
            end
            if (int'(py) != expV) begin
                $display("[ERROR] py = %h, expected %h", py, expV[9:0]);
                errorCount++;
            end
            if (frameNum != expFrame[10:0]) begin
                $display("[ERROR] frameNum = %h, expected %h", frameNum, expFrame[10:0]);
                errorCount++;
            end
            expHsync = !(expH >= hVisible + hFront && expH < hVisible + hFront + hSync);
            expVsync = !(expV >= vVisible + vFront && expV < vVisible + vFront + vSync);
            if (hsync != expHsync) begin
                $display("[ERROR] hsync = %h, expected %h at h %h",
                         hsync, expHsync, expH[9:0]);
                errorCount++;
            end
            if (vsync != expVsync) begin
                $display("[ERROR] vsync = %h, expected %h at v %h",
                         vsync, expVsync, expV[9:0]);
                errorCount++;
            end
            expColour = expectedColour(expH, expV, showMap, modelX, modelY);
            if ({red, green, blue} != expColour) begin
                $display("[ERROR] rgb = %h, expected %h at (%h,%h)",
                         {red, green, blue}, expColour, expH[9:0], expV[9:0]);
                errorCount++;
            end
            if ({red, green, blue} == colYellow) yellowSeen++;

            if (expH == 0 && expV == vVisible + 1) randomizeInputs();

            // Position update at the tick edge where host load beats buttons
            if (expH == 0 && expV == 0) begin
                if (writeNewPosition) begin
                    modelX = newPlayerX;
                    modelY = newPlayerY;
                end else begin
                    modelX = stepAxis(modelX, moveL, moveR);
                    modelY = stepAxis(modelY, moveF, moveB);
                end
            end

            if (expH == hTotal - 1) begin
                expH = 0;
                if (expV == vTotal - 1) begin
                    expV = 0;
                    expFrame++;    // Frame wrap
                end else begin
                    expV++;
                end
            end else begin
                expH++;
            end
            @(negedge clk);
        end

        if (yellowSeen == 0) begin
            $display("The player pixel never appeared on screen");
            errorCount++;
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
common/fixedPointPkg.sv
common/videoPkg.sv
video/vgaTiming.sv
video/pixelComposer.sv
player/playerState.sv
map/mapOverlay.sv
source/raybox.sv
tb/rayboxTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module rayboxTb -f tb.f -o rayboxSim
./obj_dir/rayboxSim > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
